// ==== include/frame_writer_defs.svh ====
// Frame writer address and pixel widths, buffer count, frame size limits
`ifndef FRAME_WRITER_DEFS_SVH
`define FRAME_WRITER_DEFS_SVH

// Memory side
`define FW_ADDR_W   32    // Byte address width of the AXI4-Lite port
`define FW_PIX_W    32    // One pixel per data word

// Triple buffering, index wraps 0 1 2 0
`define FW_NUM_BUF  3

// Largest frame the counters can address
`define FW_MAX_W    1280  // Pixels per line, 11 bit width field
`define FW_MAX_H    720   // Lines per frame, 10 bit height and line count

// A frame of FW_MAX_W x FW_MAX_H words needs a 20 bit pixel offset,
// and three such buffers of 4 byte pixels stay well below 4 GB,
// so FW_ADDR_W leaves room for region_base anywhere in low memory

`endif

// ==== design/frame_writer_pkg.sv ====
// Pixel beat, write request and AXI response types of the frame writer
`include "frame_writer_defs.svh"

package frame_writer_pkg;

	// One stream beat after the input register
	typedef struct packed {
		logic [`FW_PIX_W-1:0]  data;  // Pixel word
		logic                  sof;   // tuser, first pixel of a frame
		logic                  eol;   // tlast, last pixel of a line
	} pix_beat_t;

	// One addressed pixel write
	typedef struct packed {
		logic [`FW_ADDR_W-1:0] addr;  // Byte address, word aligned
		logic [`FW_PIX_W-1:0]  data;  // Pixel word
		logic [`FW_ADDR_W-1:0] base;  // Base of the buffer being filled
		logic                  last;  // Closes the frame
	} wr_req_t;

	// AXI write response codes
	typedef enum logic [1:0] {
		OKAY   = 2'b00,
		EXOKAY = 2'b01,
		SLVERR = 2'b10,
		DECERR = 2'b11
	} axi_resp_t;

endpackage

// ==== design/pipe_reg.sv ====
// Valid/ready register slice with skid entry and a type-parameterized payload
`timescale 1ns/1ps

module pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     in_ready,
	output logic     out_valid,
	output payload_t out_data,
	input  logic     out_ready
);
	logic     skid_valid;    // Skid entry holds an item
	payload_t skid_data;
	logic     in_fire;
	logic     out_free;      // Output slot empty or draining this cycle

	assign in_fire  = in_valid && in_ready;
	assign out_free = !out_valid || out_ready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid  <= 1'b0;
			skid_valid <= 1'b0;
			in_ready   <= 1'b0;                   // Opens one cycle after reset
		end else begin
			if (out_free) begin
				out_valid  <= skid_valid || in_fire; // Skid first, keeps order
				skid_valid <= 1'b0;
				in_ready   <= 1'b1;
			end else if (in_fire) begin
				skid_valid <= 1'b1;                 // Output stalled, park the item
				in_ready   <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (out_free)
			out_data <= skid_valid ? skid_data : in_data;
		if (in_fire && !out_free)
			skid_data <= in_data;
	end

endmodule

// ==== design/frame_addr_gen.sv ====
// Offset, line and buffer counters that turn pixel beats into write requests
`timescale 1ns/1ps
`include "frame_writer_defs.svh"

module frame_addr_gen (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [`FW_ADDR_W-1:0]          region_base,
	input  logic [$clog2(`FW_MAX_W+1)-1:0] frame_width,
	input  logic [$clog2(`FW_MAX_H+1)-1:0] frame_height,
	input  logic                           beat_valid,
	input  frame_writer_pkg::pix_beat_t    beat,
	output logic                           beat_ready,
	output logic                           req_valid,
	input  logic                           req_ready,
	output frame_writer_pkg::wr_req_t      req
);
	import frame_writer_pkg::*;

	localparam int AW     = `FW_ADDR_W;
	localparam int OFFS_W = $clog2(`FW_MAX_W * `FW_MAX_H);  // Pixel in frame
	localparam int LINE_W = $clog2(`FW_MAX_H + 1);          // Matches frame_height
	localparam int BUF_W  = $clog2(`FW_NUM_BUF);

	logic [OFFS_W-1:0] offset_q;     // Next pixel offset in the frame
	logic [LINE_W-1:0] line_q;       // Completed lines of the frame
	logic [BUF_W-1:0]  buf_idx;      // Buffer being filled
	logic [AW-1:0]     stride;       // Frame size in bytes
	logic [OFFS_W-1:0] cur_offset;
	logic [LINE_W-1:0] cur_line;
	logic [AW-1:0]     buf_base;
	logic              frame_end;    // Beat closes the last line
	logic              beat_fire;
	logic              frame_idle;   // Between frames, nothing pending

	// Pass-through handshake, the request is combinational from the beat
	assign req_valid  = beat_valid;
	assign beat_ready = req_ready;
	assign beat_fire  = beat_valid && req_ready;

	// tuser restarts the counts, this beat is pixel 0
	assign cur_offset = beat.sof ? '0 : offset_q;
	assign cur_line   = beat.sof ? '0 : line_q;

	assign frame_end  = beat.eol && (cur_line == frame_height - 1'b1);
	assign frame_idle = !beat_valid && (offset_q == '0) && (line_q == '0);

	// region_base + index * stride
	assign buf_base = region_base + AW'(buf_idx) * stride;

	always_comb begin
		req.addr = buf_base + AW'({cur_offset, 2'b00});  // Word address to bytes
		req.data = beat.data;
		req.base = buf_base;
		req.last = frame_end;
	end

	// Stride follows the configuration only between frames
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			stride <= '0;
		else if (frame_idle)
			stride <= AW'(frame_width) * AW'(frame_height) * AW'(4);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			offset_q <= '0;
			line_q   <= '0;
			buf_idx  <= '0;                      // First frame in buffer 0
		end else if (beat_fire) begin
			if (frame_end) begin
				offset_q <= '0;
				line_q   <= '0;
				if (buf_idx == BUF_W'(`FW_NUM_BUF - 1))
					buf_idx <= '0;                 // Wrap after the last buffer
				else
					buf_idx <= buf_idx + 1'b1;
			end else begin
				offset_q <= cur_offset + 1'b1;
				line_q   <= cur_line + LINE_W'(beat.eol);  // Count finished lines
			end
		end
	end

endmodule

// ==== design/axil_write_master.sv ====
// AXI4-Lite single write driver with response check, frame_done and error flag
`timescale 1ns/1ps
`include "frame_writer_defs.svh"

module axil_write_master (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        req_valid,
	input  frame_writer_pkg::wr_req_t   req,
	output logic                        req_ready,
	output logic [`FW_ADDR_W-1:0]       m_axil_awaddr,
	output logic                        m_axil_awvalid,
	input  logic                        m_axil_awready,
	output logic [`FW_PIX_W-1:0]        m_axil_wdata,
	output logic [`FW_PIX_W/8-1:0]      m_axil_wstrb,
	output logic                        m_axil_wvalid,
	input  logic                        m_axil_wready,
	input  frame_writer_pkg::axi_resp_t m_axil_bresp,
	input  logic                        m_axil_bvalid,
	output logic                        m_axil_bready,
	output logic                        frame_done,
	output logic [`FW_ADDR_W-1:0]       done_base,
	output logic                        wr_error
);
	import frame_writer_pkg::*;

	typedef enum logic [1:0] {IDLE, ADDR_DATA, RESP} state_t;

	state_t  state;
	wr_req_t cur_req;         // Write in flight
	logic    in_idle;
	logic    aw_done;         // AW handshake seen
	logic    w_done;          // W handshake seen
	logic    aw_hs;
	logic    w_hs;
	logic    aw_all;          // AW complete, now or earlier
	logic    w_all;
	logic    b_hs;

	assign in_idle   = (state == IDLE);
	assign req_ready = in_idle;           // One outstanding write

	// In IDLE the request drives the bus directly, saving a cycle
	assign m_axil_awvalid = in_idle ? req_valid : (state == ADDR_DATA) && !aw_done;
	assign m_axil_wvalid  = in_idle ? req_valid : (state == ADDR_DATA) && !w_done;
	assign m_axil_awaddr  = in_idle ? req.addr : cur_req.addr;
	assign m_axil_wdata   = in_idle ? req.data : cur_req.data;
	assign m_axil_wstrb   = '1;           // Full words only
	assign m_axil_bready  = (state == RESP);

	assign aw_hs  = m_axil_awvalid && m_axil_awready;
	assign w_hs   = m_axil_wvalid && m_axil_wready;
	assign aw_all = aw_done || aw_hs;
	assign w_all  = w_done || w_hs;
	assign b_hs   = m_axil_bvalid && m_axil_bready;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state      <= IDLE;
			aw_done    <= 1'b0;
			w_done     <= 1'b0;
			frame_done <= 1'b0;
			done_base  <= '0;
			wr_error   <= 1'b0;
		end else begin
			frame_done <= b_hs && cur_req.last;  // One cycle pulse
			if (b_hs && cur_req.last)
				done_base <= cur_req.base;
			if (b_hs && m_axil_bresp != OKAY)
				wr_error <= 1'b1;                  // Sticky until reset
			case (state)
				IDLE: if (req_valid) begin
					aw_done <= aw_hs;
					w_done  <= w_hs;
					state   <= (aw_hs && w_hs) ? RESP : ADDR_DATA;
				end
				ADDR_DATA: if (aw_all && w_all) begin
					aw_done <= 1'b0;
					w_done  <= 1'b0;
					state   <= RESP;
				end else begin
					aw_done <= aw_all;
					w_done  <= w_all;
				end
				RESP: if (b_hs) state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (req_valid && req_ready)
			cur_req <= req;                      // Holds the bus after IDLE
	end

endmodule

// ==== design/frame_writer_top.sv ====
// Frame writer top with stream sink, register stages and AXI4-Lite master
`timescale 1ns/1ps
`include "frame_writer_defs.svh"

module frame_writer_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic [`FW_PIX_W-1:0]           s_axis_tdata,
	input  logic                           s_axis_tvalid,
	output logic                           s_axis_tready,
	input  logic                           s_axis_tlast,
	input  logic                           s_axis_tuser,
	output logic [`FW_ADDR_W-1:0]          m_axil_awaddr,
	output logic                           m_axil_awvalid,
	input  logic                           m_axil_awready,
	output logic [`FW_PIX_W-1:0]           m_axil_wdata,
	output logic [`FW_PIX_W/8-1:0]         m_axil_wstrb,
	output logic                           m_axil_wvalid,
	input  logic                           m_axil_wready,
	input  logic [1:0]                     m_axil_bresp,
	input  logic                           m_axil_bvalid,
	output logic                           m_axil_bready,
	input  logic [`FW_ADDR_W-1:0]          region_base,
	input  logic [$clog2(`FW_MAX_W+1)-1:0] frame_width,
	input  logic [$clog2(`FW_MAX_H+1)-1:0] frame_height,
	output logic                           frame_done,
	output logic [`FW_ADDR_W-1:0]          done_base,
	output logic                           wr_error
);
	import frame_writer_pkg::*;

	pix_beat_t in_beat;         // Stream word with its flags
	pix_beat_t beat;            // Registered beat
	logic      beat_valid;
	logic      beat_ready;
	wr_req_t   gen_req;         // Addressed request, before its register
	logic      gen_valid;
	logic      gen_ready;
	wr_req_t   req;             // Registered request into the master
	logic      req_valid;
	logic      req_ready;

	assign in_beat = '{data: s_axis_tdata, sof: s_axis_tuser, eol: s_axis_tlast};

	pipe_reg #(.payload_t(pix_beat_t)) i_in_stage (
		.clk(clk), .rst_n(rst_n),
		.in_valid(s_axis_tvalid), .in_data(in_beat), .in_ready(s_axis_tready),
		.out_valid(beat_valid), .out_data(beat), .out_ready(beat_ready)
	);

	frame_addr_gen i_addr_gen (
		.clk(clk), .rst_n(rst_n),
		.region_base(region_base), .frame_width(frame_width), .frame_height(frame_height),
		.beat_valid(beat_valid), .beat(beat), .beat_ready(beat_ready),
		.req_valid(gen_valid), .req_ready(gen_ready), .req(gen_req)
	);

	pipe_reg #(.payload_t(wr_req_t)) i_req_stage (
		.clk(clk), .rst_n(rst_n),
		.in_valid(gen_valid), .in_data(gen_req), .in_ready(gen_ready),
		.out_valid(req_valid), .out_data(req), .out_ready(req_ready)
	);

	axil_write_master i_wr_master (
		.clk(clk), .rst_n(rst_n),
		.req_valid(req_valid), .req(req), .req_ready(req_ready),
		.m_axil_awaddr(m_axil_awaddr), .m_axil_awvalid(m_axil_awvalid),
		.m_axil_awready(m_axil_awready),
		.m_axil_wdata(m_axil_wdata), .m_axil_wstrb(m_axil_wstrb),
		.m_axil_wvalid(m_axil_wvalid), .m_axil_wready(m_axil_wready),
		.m_axil_bresp(axi_resp_t'(m_axil_bresp)),   // Raw code to enum
		.m_axil_bvalid(m_axil_bvalid), .m_axil_bready(m_axil_bready),
		.frame_done(frame_done), .done_base(done_base), .wr_error(wr_error)
	);

endmodule

// ==== dv/frame_writer_assertions.sv ====
// Bound AXI4-Lite hold checks, address alignment and frame_done pulse width
`timescale 1ns/1ps
`include "frame_writer_defs.svh"

module frame_writer_assertions (
	input logic                  clk,
	input logic                  rst_n,
	input logic [`FW_ADDR_W-1:0] m_axil_awaddr,
	input logic                  m_axil_awvalid,
	input logic                  m_axil_awready,
	input logic [`FW_PIX_W-1:0]  m_axil_wdata,
	input logic                  m_axil_wvalid,
	input logic                  m_axil_wready,
	input logic                  frame_done
);
	int fail_count = 0;    // Violations so far, watched by the testbench

	task automatic record_violation(input string what);
		$error("%s", what);
		fail_count++;
	endtask

	aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_axil_awvalid && !m_axil_awready |=> m_axil_awvalid && $stable(m_axil_awaddr))
		else record_violation("awvalid or awaddr changed before awready");

	w_hold: assert property (@(posedge clk) disable iff (!rst_n)
		m_axil_wvalid && !m_axil_wready |=> m_axil_wvalid && $stable(m_axil_wdata))
		else record_violation("wvalid or wdata changed before wready");

	aw_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		m_axil_awvalid |-> m_axil_awaddr[1:0] == 2'b00)
		else record_violation("awaddr is not word aligned");

	done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		frame_done |=> !frame_done)
		else record_violation("frame_done high for two cycles");

endmodule

bind frame_writer_top frame_writer_assertions i_protocol_check (.*);

// ==== dv/frame_writer_tb.sv ====
// Frame writer testbench with memory slave model, directed frame tests and timeout
`timescale 1ns/1ps
`include "frame_writer_defs.svh"

module frame_writer_tb;
	localparam int TOTAL_PIX = 12 + 4 * 6 + 3 * 32 + 20 + 12;  // Pixels over all tests
	localparam int TIMEOUT   = TOTAL_PIX * 8 + 200;

	logic                           clk;
	logic                           rst_n;
	logic [`FW_PIX_W-1:0]           s_axis_tdata;
	logic                           s_axis_tvalid;
	logic                           s_axis_tready;
	logic                           s_axis_tlast;
	logic                           s_axis_tuser;
	logic [`FW_ADDR_W-1:0]          m_axil_awaddr;
	logic                           m_axil_awvalid;
	logic                           m_axil_awready;
	logic [`FW_PIX_W-1:0]           m_axil_wdata;
	logic [`FW_PIX_W/8-1:0]         m_axil_wstrb;
	logic                           m_axil_wvalid;
	logic                           m_axil_wready;
	logic [1:0]                     m_axil_bresp;
	logic                           m_axil_bvalid;
	logic                           m_axil_bready;
	logic [`FW_ADDR_W-1:0]          region_base;
	logic [$clog2(`FW_MAX_W+1)-1:0] frame_width;
	logic [$clog2(`FW_MAX_H+1)-1:0] frame_height;
	logic                           frame_done;
	logic [`FW_ADDR_W-1:0]          done_base;
	logic                           wr_error;

	logic [15:0]           lfsr = 16'd64023;    // Galois LFSR state
	logic [31:0]           mem[logic [31:0]];   // Slave memory by byte address
	int                    wr_count[logic [31:0]];
	logic [`FW_ADDR_W-1:0] done_q[$];           // done_base at each frame_done
	int                    done_count;
	int                    write_total;
	int                    cycles;
	bit                    rand_delays;         // Slave waits 0 to 3 cycles
	bit                    err_en;
	logic [`FW_ADDR_W-1:0] err_addr;            // Gets SLVERR when err_en

	frame_writer_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on the first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] exp,
			input logic [31:0] got);
		$display("** Error at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, got);
		stop_run();
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t ns: %s", $time, what);
		stop_run();
	endtask

	function automatic logic lfsr_bit();
		logic b;
		b = lfsr[0];
		lfsr = {1'b0, lfsr[15:1]} ^ (b ? 16'hB400 : 16'h0000);  // Taps 16 14 13 11
		return b;
	endfunction

	function automatic int slave_delay();
		int d;
		if (!rand_delays)
			return 0;
		d = lfsr_bit();
		d = 2 * d + lfsr_bit();                 // Two bits, two steps
		return d;
	endfunction

	// Test id, frame number and offset make every pixel unique
	function automatic logic [31:0] pix_value(input int t, input int f, input int off);
		return {8'(t), 8'(f), 16'(off)};
	endfunction

	// One AXI4-Lite write, entered on the negedge that sees awvalid
	task automatic serve_write();
		logic [31:0] a;
		logic [31:0] d;
		int          da;
		int          dw;
		int          db;
		a  = m_axil_awaddr;
		d  = m_axil_wdata;
		da = slave_delay();
		dw = slave_delay();
		db = slave_delay();
		assert (m_axil_wvalid === 1'b1) else report_failure("awvalid raised without wvalid");
		assert (m_axil_wstrb === 4'hF) else report_mismatch("m_axil_wstrb", 32'hF, m_axil_wstrb);
		for (int c = 0; c <= (da > dw ? da : dw); c++) begin
			m_axil_awready = (c == da);           // Taken at the next posedge
			m_axil_wready  = (c == dw);
			@(negedge clk);
		end
		m_axil_awready = 1'b0;
		m_axil_wready  = 1'b0;
		mem[a]      = d;
		wr_count[a] = wr_count.exists(a) ? wr_count[a] + 1 : 1;
		write_total++;
		repeat (db) @(negedge clk);
		m_axil_bresp  = (err_en && a == err_addr) ? 2'b10 : 2'b00;  // SLVERR or OKAY
		m_axil_bvalid = 1'b1;
		while (!m_axil_bready) @(negedge clk);
		@(negedge clk);                         // Response handshake in between
		m_axil_bvalid = 1'b0;
		m_axil_bresp  = 2'b00;
	endtask

	initial begin
		@(negedge clk);
		forever begin
			if (m_axil_awvalid === 1'b1)
				serve_write();
			else
				@(negedge clk);
		end
	end

	always @(negedge clk) begin
		if (frame_done === 1'b1) begin
			done_q.push_back(done_base);
			done_count++;
		end
	end

	// Watchdog on cycles and on the bound protocol checks
	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			assert (cycles <= TIMEOUT) else report_failure("timeout, no progress from the DUT");
			assert (i_dut.i_protocol_check.fail_count == 0)
				else report_failure("AXI4-Lite protocol assertion failed");
		end
	end

	task automatic start_test(input logic [31:0] base, input int w, input int h);
		region_base  = base;                    // Config only changes in reset
		frame_width  = w;
		frame_height = h;
		rst_n        = 1'b0;
		mem.delete();
		wr_count.delete();
		done_q.delete();
		done_count  = 0;
		write_total = 0;
		err_en      = 1'b0;
		rand_delays = 1'b0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
	endtask

	task automatic send_beat(input logic [31:0] d, input logic sof, input logic eol);
		s_axis_tdata  = d;
		s_axis_tuser  = sof;
		s_axis_tlast  = eol;
		s_axis_tvalid = 1'b1;
		while (!s_axis_tready) @(negedge clk);
		@(negedge clk);                         // Beat taken at the posedge
		s_axis_tvalid = 1'b0;
	endtask

	task automatic send_frame(input int t, input int f, input int w, input int lines);
		for (int l = 0; l < lines; l++)
			for (int c = 0; c < w; c++)
				send_beat(pix_value(t, f, l * w + c), (l == 0 && c == 0), (c == w - 1));
	endtask

	task automatic wait_frames(input int n);
		while (done_count < n) @(negedge clk);
	endtask

	// Buffer at base must hold frame f of test t, pixel by pixel
	task automatic check_frame(input logic [31:0] base, input int t, input int f,
			input int w, input int h);
		logic [31:0] a;
		for (int off = 0; off < w * h; off++) begin
			a = base + 32'(off) * 4;
			assert (mem.exists(a)) else report_failure($sformatf("no write reached 0x%08h", a));
			assert (mem[a] == pix_value(t, f, off))
				else report_mismatch($sformatf("mem[0x%08h]", a), pix_value(t, f, off), mem[a]);
		end
	endtask

	task automatic check_done(input int idx, input logic [31:0] exp);
		assert (done_q.size() > idx) else report_failure("a frame_done pulse is missing");
		assert (done_q[idx] == exp) else report_mismatch("done_base", exp, done_q[idx]);
	endtask

	task automatic test_single_frame();
		start_test(32'h1000_0000, 4, 3);
		send_frame(1, 0, 4, 3);
		wait_frames(1);
		repeat (10) @(negedge clk);             // Room for a stray second pulse
		check_frame(32'h1000_0000, 1, 0, 4, 3);
		check_done(0, 32'h1000_0000);
		assert (done_count == 1) else report_mismatch("frame_done count", 1, done_count);
	endtask

	task automatic test_buffer_rotation();
		logic [31:0] stride;
		stride = 3 * 2 * 4;                     // Width x height x 4 bytes
		start_test(32'h2000_0000, 3, 2);
		for (int f = 0; f < 4; f++)
			send_frame(2, f, 3, 2);
		wait_frames(4);
		for (int f = 0; f < 4; f++)
			check_done(f, 32'h2000_0000 + (f % 3) * stride);
		check_frame(32'h2000_0000, 2, 3, 3, 2);  // Frame 4 over frame 1
		check_frame(32'h2000_0000 + stride, 2, 1, 3, 2);
		check_frame(32'h2000_0000 + 2 * stride, 2, 2, 3, 2);
		assert (wr_count[32'h2000_0000] == 2)
			else report_mismatch("writes to buffer 0", 2, wr_count[32'h2000_0000]);
	endtask

	task automatic test_random_delays();
		logic [31:0] stride;
		logic [31:0] a;
		stride = 8 * 4 * 4;
		start_test(32'h3000_0000, 8, 4);
		rand_delays = 1'b1;
		for (int f = 0; f < 3; f++)
			send_frame(3, f, 8, 4);             // Back to back, slave stalls
		wait_frames(3);
		for (int f = 0; f < 3; f++) begin
			check_done(f, 32'h3000_0000 + f * stride);
			check_frame(32'h3000_0000 + f * stride, 3, f, 8, 4);
			for (int off = 0; off < 32; off++) begin
				a = 32'h3000_0000 + f * stride + off * 4;
				assert (wr_count[a] == 1)
					else report_mismatch($sformatf("writes to 0x%08h", a), 1, wr_count[a]);
			end
		end
		assert (write_total == 96) else report_mismatch("write count", 96, write_total);
	endtask

	task automatic test_mid_frame_restart();
		start_test(32'h4000_0000, 4, 3);
		send_frame(4, 0, 4, 2);                 // Two lines, then cut off
		send_frame(4, 1, 4, 3);                 // tuser restarts on the same buffer
		wait_frames(1);
		repeat (20) @(negedge clk);
		check_frame(32'h4000_0000, 4, 1, 4, 3);
		check_done(0, 32'h4000_0000);
		assert (done_count == 1) else report_mismatch("frame_done count", 1, done_count);
	endtask

	task automatic test_slave_error();
		start_test(32'h5000_0000, 4, 3);
		assert (wr_error == 1'b0) else report_mismatch("wr_error", 0, wr_error);
		err_en   = 1'b1;
		err_addr = 32'h5000_0000 + 5 * 4;       // Pixel 5 answered with SLVERR
		send_frame(5, 0, 4, 3);
		wait_frames(1);
		assert (wr_error == 1'b1) else report_mismatch("wr_error", 1, wr_error);
		check_frame(32'h5000_0000, 5, 0, 4, 3);
		check_done(0, 32'h5000_0000);
		repeat (5) @(negedge clk);
		assert (wr_error == 1'b1) else report_mismatch("wr_error", 1, wr_error);  // Sticky
	endtask

	initial begin
		rst_n          = 1'b0;
		s_axis_tdata   = '0;
		s_axis_tvalid  = 1'b0;
		s_axis_tlast   = 1'b0;
		s_axis_tuser   = 1'b0;
		m_axil_awready = 1'b0;
		m_axil_wready  = 1'b0;
		m_axil_bresp   = 2'b00;
		m_axil_bvalid  = 1'b0;
		region_base    = '0;
		frame_width    = '0;
		frame_height   = '0;
		done_count     = 0;
		write_total    = 0;
		rand_delays    = 1'b0;
		err_en         = 1'b0;
		err_addr       = '0;
		test_single_frame();
		test_buffer_rotation();
		test_random_delays();
		test_mid_frame_restart();
		test_slave_error();
		repeat (5) @(negedge clk);
		if (i_dut.i_protocol_check.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			stop_run();
		end
	end

endmodule

// ==== verilog.f ====
+incdir+include
design/frame_writer_pkg.sv
design/pipe_reg.sv
design/frame_addr_gen.sv
design/axil_write_master.sv
design/frame_writer_top.sv
dv/frame_writer_assertions.sv
dv/frame_writer_tb.sv
